// File: verilog/memtest_cfg.svh
`ifndef MEMTEST_CFG_SVH
`define MEMTEST_CFG_SVH

//==============================
// memory geometry
//==============================

// word address width, 64 words swept
`define MT_ADDR_W 6

// 64 data bits plus the 8-bit check byte
`define MT_DATA_W 72

//==============================
// tester sizing
//==============================

// command FIFO entries
`define MT_FIFO_DEPTH 4

// free-running seed counter
`define MT_CNT_W 64

`endif

// File: verilog/memtest_pkg.sv
`include "memtest_cfg.svh"

package memtest_pkg;

	// command opcodes
	typedef enum logic {
		OP_WRITE,
		OP_READ
	} mem_op_e;

	// tester FSM
	typedef enum logic [2:0] {
		ST_IDLE, ST_WRITE, ST_WDRAIN, ST_READ,
		ST_RDRAIN, ST_PASS, ST_FAIL
	} test_state_e;

	typedef struct packed {
		mem_op_e               op;
		logic [`MT_ADDR_W-1:0] addr;
		logic [`MT_DATA_W-1:0] wdata;   // don't care for reads
	} mem_cmd_t;

	typedef struct packed {
		logic [`MT_DATA_W-1:0] rdata;
	} mem_rsp_t;

	//==============================
	// test pattern
	//==============================
	// top byte is a check byte over the two intermediate terms
	function automatic logic [`MT_DATA_W-1:0] mt_pattern(
		input logic [`MT_CNT_W-1:0]  seed,
		input logic [`MT_ADDR_W-1:0] addr
	);
		logic [`MT_CNT_W-1:0] y0;
		logic [`MT_CNT_W-1:0] y1;
		logic [`MT_CNT_W-1:0] y2;
		logic [7:0]           z;
		y0 = seed + `MT_CNT_W'(addr);
		y1 = {y0[`MT_CNT_W/2-1:0], y0[`MT_CNT_W-1:`MT_CNT_W/2]} ^ seed;   // swap halves
		y2 = y1 + seed;
		z  = y1[7:0] + y2[7:0];
		return {z, y2};
	endfunction

endpackage

// File: verilog/cmd_fifo.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module cmd_fifo #(
	parameter int DEPTH = `MT_FIFO_DEPTH
) (
	input  logic                  iCLK,
	input  logic                  iRST_n,
	input  memtest_pkg::mem_cmd_t in_cmd,
	input  logic                  in_valid,
	output logic                  in_ready,
	output memtest_pkg::mem_cmd_t out_cmd,
	output logic                  out_valid,
	input  logic                  out_ready
);

	import memtest_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	mem_cmd_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             push;
	logic             pop;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign in_ready  = count < (PTR_W+1)'(DEPTH);
	assign out_valid = count != '0;
	assign out_cmd   = mem[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge iCLK)
	begin
		if (!iRST_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// storage
	always_ff @(posedge iCLK)
	begin
		if (push)
			mem[wr_ptr] <= in_cmd;
	end

endmodule

// File: verilog/avl_cmd_master.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module avl_cmd_master (
	input  logic                  iCLK,
	input  logic                  iRST_n,
	input  memtest_pkg::mem_cmd_t cmd,
	input  logic                  cmd_valid,
	output logic                  cmd_ready,
	output logic                  writes_done,
	output memtest_pkg::mem_rsp_t rsp,
	output logic                  rsp_valid,
	input  logic                  avl_waitrequest_n,
	input  logic                  avl_readdatavalid,
	input  logic [`MT_DATA_W-1:0] avl_readdata,
	output logic [`MT_ADDR_W-1:0] avl_address,
	output logic [`MT_DATA_W-1:0] avl_writedata,
	output logic                  avl_read,
	output logic                  avl_write,
	output logic                  avl_burstbegin
);

	import memtest_pkg::*;

	logic bus_busy;
	logic last_op_wr;   // last loaded op was a write
	logic load;

	assign bus_busy       = avl_read || avl_write;
	assign avl_burstbegin = bus_busy;   // single-word accesses

	// bus registers free, or freed this cycle
	assign cmd_ready = !bus_busy || avl_waitrequest_n;
	assign load      = cmd_ready && cmd_valid;

	// nothing waiting at the input either
	assign writes_done = !bus_busy && !cmd_valid && last_op_wr;

	//==============================
	// bus control
	//==============================
	always_ff @(posedge iCLK)
	begin
		if (!iRST_n)
		begin
			avl_read   <= 1'b0;
			avl_write  <= 1'b0;
			last_op_wr <= 1'b1;
			rsp_valid  <= 1'b0;
		end
		else
		begin
			rsp_valid <= avl_readdatavalid;
			if (load)
			begin
				avl_write  <= cmd.op == OP_WRITE;
				avl_read   <= cmd.op == OP_READ;
				last_op_wr <= cmd.op == OP_WRITE;
			end
			else if (cmd_ready)
			begin
				avl_write <= 1'b0;   // accepted, nothing behind it
				avl_read  <= 1'b0;
			end
		end
	end

	// address and data held through waitrequest
	always_ff @(posedge iCLK)
	begin
		if (load)
		begin
			avl_address   <= cmd.addr;
			avl_writedata <= cmd.wdata;
		end
	end

	// read data back to the tester
	always_ff @(posedge iCLK)
	begin
		if (avl_readdatavalid)
			rsp.rdata <= avl_readdata;
	end

endmodule

// File: verilog/mem_tester.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module mem_tester (
	input  logic                     iCLK,
	input  logic                     iRST_n,
	input  logic                     iBUTTON,
	input  logic                     local_init_done,
	input  logic                     writes_done,
	output memtest_pkg::mem_cmd_t    cmd,
	output logic                     cmd_valid,
	input  logic                     cmd_ready,
	input  memtest_pkg::mem_rsp_t    rsp,
	input  logic                     rsp_valid,
	output logic                     test_pass,
	output logic                     test_fail,
	output logic                     test_complete,
	output memtest_pkg::test_state_e state
);

	import memtest_pkg::*;

	localparam int RD_LIMIT = `MT_FIFO_DEPTH + 1;   // reads allowed in flight
	localparam int INF_W    = $clog2(RD_LIMIT + 1);

	//==============================
	// declarations
	//==============================
	logic [`MT_CNT_W-1:0]  clk_cnt;
	logic [`MT_CNT_W-1:0]  seed;
	logic [1:0]            pre_button;
	logic                  trigger;
	logic                  start;
	logic                  push;
	logic                  last_addr;
	logic [`MT_ADDR_W-1:0] next_addr;
	logic [INF_W-1:0]      inflight;
	logic [INF_W-1:0]      inflight_nxt;
	logic                  offer_rd;
	logic [`MT_ADDR_W-1:0] exp_addr;
	logic [`MT_DATA_W-1:0] exp_data;
	logic                  mismatch;

	assign start     = local_init_done && trigger;
	assign push      = cmd_valid && cmd_ready;
	assign last_addr = &cmd.addr;
	assign next_addr = cmd.addr + 1'b1;

	// expected word for the next response
	assign exp_data = mt_pattern(seed, exp_addr);
	assign mismatch = rsp.rdata != exp_data;

	// reads pushed but not yet answered
	always_comb
	begin
		inflight_nxt = inflight;
		if (push && state == ST_READ)
			inflight_nxt = inflight_nxt + 1'b1;
		if (rsp_valid)
			inflight_nxt = inflight_nxt - 1'b1;
	end

	// next read may go out once the current offer is taken
	assign offer_rd = (push || !cmd_valid) && !(push && last_addr) &&
		(inflight_nxt < INF_W'(RD_LIMIT));

	//==============================
	// seed counter and button sync
	//==============================
	always_ff @(posedge iCLK)
	begin
		if (!iRST_n)
		begin
			clk_cnt    <= '0;
			pre_button <= 2'b11;
			trigger    <= 1'b0;
		end
		else
		begin
			clk_cnt    <= clk_cnt + 1'b1;
			pre_button <= {pre_button[0], iBUTTON};
			trigger    <= !pre_button[0] && pre_button[1];   // falling edge
		end
	end

	//==============================
	// control FSM
	//==============================
	always_ff @(posedge iCLK)
	begin
		if (!iRST_n)
		begin
			state     <= ST_IDLE;
			cmd_valid <= 1'b0;
			inflight  <= '0;
			exp_addr  <= '0;
		end
		else
		begin
			inflight <= inflight_nxt;
			case (state)
				ST_IDLE:
				begin
					exp_addr <= '0;
					if (start)
					begin
						cmd_valid <= 1'b1;   // first write offered right away
						state     <= ST_WRITE;
					end
				end
				ST_WRITE:
				begin
					if (push && last_addr)
					begin
						cmd_valid <= 1'b0;
						state     <= ST_WDRAIN;
					end
				end
				ST_WDRAIN:
				begin
					// all writes taken by the bus
					if (writes_done)
					begin
						cmd_valid <= 1'b1;
						state     <= ST_READ;
					end
				end
				ST_READ:
				begin
					if (push || !cmd_valid)
						cmd_valid <= offer_rd;
					if (push && last_addr)
						state <= ST_RDRAIN;
				end
				ST_RDRAIN: ;   // wait for the remaining responses
				default:
					cmd_valid <= cmd_valid && !cmd_ready;   // finish a held offer, then stop
			endcase

			// in-order compare, overrides the issue side
			if (rsp_valid && (state == ST_READ || state == ST_RDRAIN))
			begin
				exp_addr <= exp_addr + 1'b1;
				if (mismatch)
					state <= ST_FAIL;
				else if (&exp_addr)
					state <= ST_PASS;
			end
		end
	end

	//==============================
	// command payload
	//==============================
	always_ff @(posedge iCLK)
	begin
		case (state)
			ST_IDLE:
			begin
				if (start)
				begin
					seed      <= clk_cnt;
					cmd.op    <= OP_WRITE;
					cmd.addr  <= '0;
					cmd.wdata <= mt_pattern(clk_cnt, '0);
				end
			end
			ST_WRITE:
			begin
				if (push)
				begin
					cmd.addr  <= next_addr;
					cmd.wdata <= mt_pattern(seed, next_addr);   // registered pattern
				end
			end
			ST_WDRAIN:
			begin
				if (writes_done)
				begin
					cmd.op   <= OP_READ;
					cmd.addr <= '0;
				end
			end
			ST_READ:
			begin
				if (offer_rd)
					cmd.addr <= next_addr;
			end
			default: ;
		endcase
	end

	// result decode
	assign test_pass     = state == ST_PASS;
	assign test_fail     = state == ST_FAIL;
	assign test_complete = test_pass || test_fail;

endmodule

// File: verilog/memtest_top.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module memtest_top (
	input  logic                     iCLK,
	input  logic                     iRST_n,
	input  logic                     iBUTTON,
	input  logic                     local_init_done,
	input  logic                     avl_waitrequest_n,
	input  logic                     avl_readdatavalid,
	input  logic [`MT_DATA_W-1:0]    avl_readdata,
	output logic [`MT_ADDR_W-1:0]    avl_address,
	output logic [`MT_DATA_W-1:0]    avl_writedata,
	output logic                     avl_read,
	output logic                     avl_write,
	output logic                     avl_burstbegin,
	output logic                     test_pass,
	output logic                     test_fail,
	output logic                     test_complete,
	output memtest_pkg::test_state_e state
);

	import memtest_pkg::*;

	//==============================
	// interconnect
	//==============================
	mem_cmd_t tst_cmd;     // tester to FIFO
	logic     tst_valid;
	logic     tst_ready;
	mem_cmd_t fifo_cmd;    // FIFO to master
	logic     fifo_valid;
	logic     fifo_ready;
	mem_rsp_t rsp;
	logic     rsp_valid;
	logic     writes_done;

	mem_tester u_tester (
		.iCLK            (iCLK),
		.iRST_n          (iRST_n),
		.iBUTTON         (iBUTTON),
		.local_init_done (local_init_done),
		.writes_done     (writes_done),
		.cmd             (tst_cmd),
		.cmd_valid       (tst_valid),
		.cmd_ready       (tst_ready),
		.rsp             (rsp),
		.rsp_valid       (rsp_valid),
		.test_pass       (test_pass),
		.test_fail       (test_fail),
		.test_complete   (test_complete),
		.state           (state)
	);

	cmd_fifo #(
		.DEPTH (`MT_FIFO_DEPTH)
	) u_fifo (
		.iCLK      (iCLK),
		.iRST_n    (iRST_n),
		.in_cmd    (tst_cmd),
		.in_valid  (tst_valid),
		.in_ready  (tst_ready),
		.out_cmd   (fifo_cmd),
		.out_valid (fifo_valid),
		.out_ready (fifo_ready)
	);

	avl_cmd_master u_master (
		.iCLK              (iCLK),
		.iRST_n            (iRST_n),
		.cmd               (fifo_cmd),
		.cmd_valid         (fifo_valid),
		.cmd_ready         (fifo_ready),
		.writes_done       (writes_done),
		.rsp               (rsp),
		.rsp_valid         (rsp_valid),
		.avl_waitrequest_n (avl_waitrequest_n),
		.avl_readdatavalid (avl_readdatavalid),
		.avl_readdata      (avl_readdata),
		.avl_address       (avl_address),
		.avl_writedata     (avl_writedata),
		.avl_read          (avl_read),
		.avl_write         (avl_write),
		.avl_burstbegin    (avl_burstbegin)
	);

endmodule

// File: sim/memtest_props.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module memtest_props (
	input logic                  iCLK,
	input logic                  iRST_n,
	input logic                  iBUTTON,
	input logic                  avl_waitrequest_n,
	input logic [`MT_ADDR_W-1:0] avl_address,
	input logic [`MT_DATA_W-1:0] avl_writedata,
	input logic                  avl_read,
	input logic                  avl_write,
	input logic                  avl_burstbegin,
	input logic                  test_pass,
	input logic                  test_fail,
	input logic                  test_complete,
	input logic [`MT_CNT_W-1:0]  seed
);

	localparam logic [`MT_ADDR_W:0] WORDS = {1'b1, {`MT_ADDR_W{1'b0}}};

	logic                 pressed;
	logic [`MT_ADDR_W:0]  wr_cnt;   // accepted writes so far
	logic [`MT_ADDR_W:0]  rd_cnt;
	logic [`MT_CNT_W-1:0] sum;
	logic [`MT_CNT_W-1:0] mix;
	logic                 wr_ok;
	logic                 rd_ok;
	logic                 err_idle = 1'b0;
	logic                 err_hold = 1'b0;
	logic                 err_order = 1'b0;
	logic                 err_result = 1'b0;
	logic                 prop_err;

	// seed plus address, halves swapped, xor seed
	assign sum = seed + `MT_CNT_W'(avl_address);
	assign mix = {sum[`MT_CNT_W/2-1:0], sum[`MT_CNT_W-1:`MT_CNT_W/2]} ^ seed;

	assign wr_ok = !(avl_write && avl_waitrequest_n) ||
		(wr_cnt < WORDS && avl_address == wr_cnt[`MT_ADDR_W-1:0] &&
		avl_writedata[`MT_CNT_W-1:0] == mix + seed &&
		avl_writedata[`MT_DATA_W-1:`MT_CNT_W] == mix[7:0] + avl_writedata[7:0]);
	assign rd_ok = !(avl_read && avl_waitrequest_n) ||
		(wr_cnt == WORDS && rd_cnt < WORDS && avl_address == rd_cnt[`MT_ADDR_W-1:0]);
	assign prop_err = err_idle || err_hold || err_order || err_result;

	always_ff @(posedge iCLK)
	begin
		if (!iRST_n)
		begin
			pressed <= 1'b0;
			wr_cnt  <= '0;
			rd_cnt  <= '0;
		end
		else
		begin
			if (!iBUTTON)
				pressed <= 1'b1;
			if (avl_write && avl_waitrequest_n)
				wr_cnt <= wr_cnt + 1'b1;
			if (avl_read && avl_waitrequest_n)
				rd_cnt <= rd_cnt + 1'b1;
		end
	end

	//==============================
	// bus and result checks
	//==============================
	a_idle: assert property (@(posedge iCLK) disable iff (!iRST_n)
		!pressed |-> !(avl_read || avl_write || test_pass || test_fail || test_complete))
	else
	begin
		$error("bus or status active before the button press");
		err_idle = 1'b1;
	end

	a_hold: assert property (@(posedge iCLK) disable iff (!iRST_n)
		(avl_read || avl_write) && !avl_waitrequest_n |=> $stable(avl_read) &&
		$stable(avl_write) && $stable(avl_address) && $stable(avl_writedata))
	else
	begin
		$error("access changed while waitrequest was asserted");
		err_hold = 1'b1;
	end

	// burstbegin, ascending sweeps, check byte
	a_order: assert property (@(posedge iCLK) disable iff (!iRST_n)
		avl_burstbegin == (avl_read || avl_write) && wr_ok && rd_ok)
	else
	begin
		$error("bad access at address %0d", avl_address);
		err_order = 1'b1;
	end

	// a pass needs the full write and read sweeps
	a_result: assert property (@(posedge iCLK) disable iff (!iRST_n)
		test_complete |=> test_complete && $stable(test_pass) && $stable(test_fail) &&
		(test_pass != test_fail) && wr_cnt == WORDS && (!test_pass || rd_cnt == WORDS))
	else
	begin
		$error("result did not hold, was not exactly one of pass and fail, or came early");
		err_result = 1'b1;
	end

endmodule

bind memtest_top memtest_props u_props (.*, .seed(u_tester.seed));

// File: sim/memtest_tb.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module memtest_tb;

	import memtest_pkg::*;

	localparam logic [`MT_ADDR_W-1:0] FAULT_ADDR = 6'd37;   // word that gets a flipped bit

	logic                  iCLK = 1'b0;
	logic                  iRST_n = 1'b0;
	logic                  iBUTTON = 1'b1;
	logic                  local_init_done = 1'b0;
	logic                  avl_waitrequest_n = 1'b0;
	logic                  avl_readdatavalid = 1'b0;
	logic [`MT_DATA_W-1:0] avl_readdata = '0;
	logic [`MT_ADDR_W-1:0] avl_address;
	logic [`MT_DATA_W-1:0] avl_writedata;
	logic                  avl_read;
	logic                  avl_write;
	logic                  avl_burstbegin;
	logic                  test_pass;
	logic                  test_fail;
	logic                  test_complete;
	test_state_e           state;

	logic                  rst_req = 1'b0;      // applied on the next rising edge
	logic                  button_req = 1'b1;
	logic                  fault_en = 1'b0;
	integer                seed = 69;
	int                    cyc = 0;
	int                    lat;
	int                    due;
	int                    last_due = 0;
	logic [`MT_DATA_W-1:0] word;
	logic [`MT_DATA_W-1:0] mem [1 << `MT_ADDR_W];
	logic [`MT_DATA_W-1:0] rd_q [$];           // read data in flight
	int                    due_q [$];

	memtest_top u_memtest_top (.*);

	initial
	begin
		forever #10 iCLK = ~iCLK;
	end

	always @(posedge iCLK)
	begin
		iRST_n          <= rst_req;
		iBUTTON         <= button_req;
		local_init_done <= rst_req;   // memory ready once out of reset
	end

	//==============================
	// Avalon memory model
	//==============================
	always @(posedge iCLK)
	begin
		cyc = cyc + 1;
		avl_waitrequest_n <= ($random(seed) & 3) != 0;   // ready about 3 cycles in 4
		if (!iRST_n)
		begin
			rd_q.delete();
			due_q.delete();
			avl_readdatavalid <= 1'b0;
		end
		else
		begin
			if (avl_write && avl_waitrequest_n)
			begin
				word = avl_writedata;
				if (fault_en && avl_address == FAULT_ADDR)
					word[0] = ~word[0];
				mem[avl_address] = word;
			end
			if (avl_read && avl_waitrequest_n)
			begin
				lat = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
				due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;   // stay in order
				last_due = due;
				rd_q.push_back(mem[avl_address]);
				due_q.push_back(due);
			end
			if (due_q.size() != 0 && due_q[0] <= cyc)
			begin
				avl_readdatavalid <= 1'b1;
				avl_readdata      <= rd_q.pop_front();
				void'(due_q.pop_front());
			end
			else
				avl_readdatavalid <= 1'b0;
		end
	end

	// bound protocol checks
	always @(negedge iCLK)
	begin
		if (u_memtest_top.u_props.prop_err)
		begin
			$display("tests failed");
			$fatal(1, "a protocol assertion failed at %0t", $time);
		end
	end

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	//==============================
	// one full sweep
	//==============================
	task automatic run_once(input logic fault);
		int n;
		@(negedge iCLK);
		rst_req  = 1'b0;
		fault_en = fault;
		repeat (10) @(negedge iCLK);
		rst_req = 1'b1;
		repeat (3) @(negedge iCLK);
		button_req = 1'b0;
		repeat (6) @(negedge iCLK);
		button_req = 1'b1;
		n = 0;
		while (state == ST_IDLE && n < 20)
		begin
			@(negedge iCLK);
			n++;
		end
		if (state == ST_IDLE)
			report_timeout("the tester to start");
		n = 0;
		while (!test_complete && n < 20000)
		begin
			@(negedge iCLK);
			n++;
		end
		if (!test_complete)
			report_timeout("test_complete");
		repeat (5) @(negedge iCLK);   // result must hold
		if (test_pass !== !fault || test_fail !== fault ||
			state !== (fault ? ST_FAIL : ST_PASS))
		begin
			$display("Fail at %0t: pass=%b fail=%b state=%s with fault=%b",
				$time, test_pass, test_fail, state.name(), fault);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	initial
	begin
		run_once(1'b0);
		run_once(1'b1);   // stuck bit at FAULT_ADDR
		$display("all tests passed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+verilog
verilog/memtest_pkg.sv
verilog/cmd_fifo.sv
verilog/avl_cmd_master.sv
verilog/mem_tester.sv
verilog/memtest_top.sv
sim/memtest_props.sv
sim/memtest_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run memtest_tb with Verilator, result taken from sim.log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module memtest_tb -f sources.f -o memtest_sim &&
./obj_dir/memtest_sim +verilator+error+limit+100 | tee sim.log
grep -qx "all tests passed" sim.log && echo "simulation PASSED" || {
	echo "simulation FAILED"
	exit 1
}
